// ==== rtl/rv_regfile_consts.svh ====
`ifndef RV_REGFILE_CONSTS_SVH
`define RV_REGFILE_CONSTS_SVH

// ------------------------------------------------------------
// Register file geometry
// ------------------------------------------------------------
`define RF_NUM_GPR      16
`define RF_IDX_W        4
`define RF_XLEN         32

// ------------------------------------------------------------
// Machine CSR addresses
// ------------------------------------------------------------
`define CSR_MSTATUS     12'h300
`define CSR_MTVEC       12'h305
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342
`define CSR_MVENDORID   12'hF11
`define CSR_MARCHID     12'hF12

// Read-only identification values
`define MVENDORID_VAL   32'h5256_3245
`define MARCHID_VAL     32'h0001_0E32

// ------------------------------------------------------------
// Trap constants
// ------------------------------------------------------------
// MPP = M-mode, also loaded on ecall
`define MSTATUS_RESET   32'h0000_1800
`define MCAUSE_ECALL_M  32'd11

`endif

// ==== rtl/rv_regfile_pkg.sv ====
`include "rv_regfile_consts.svh"

package rv_regfile_pkg;

  // Register index, x0..x15
  typedef logic [`RF_IDX_W-1:0] gpr_idx_t;

  // 12-bit CSR address as carried in the immediate field
  typedef logic [11:0] csr_addr_t;

  // ------------------------------------------------------------
  // mstatus field layout, only the machine-mode bits
  // ------------------------------------------------------------
  typedef struct packed {
    logic [18:0] rsvd_hi;    // 31:13
    logic [1:0]  mpp;        // 12:11
    logic [2:0]  rsvd_mid;   // 10:8
    logic        mpie;       // 7
    logic [2:0]  rsvd_lo;    // 6:4
    logic        mie;        // 3
    logic [2:0]  rsvd_base;  // 2:0
  } mstatus_fields_t;

  // Raw word for csrr/csrw, field view for trap return
  typedef union packed {
    logic [`RF_XLEN-1:0] word;
    mstatus_fields_t     fld;
  } mstatus_t;

endpackage

// ==== rtl/gpr_write_decode.sv ====
`timescale 1ns/1ps
`include "rv_regfile_consts.svh"

module gpr_write_decode (
  input  logic                       wbu_valid,
  input  logic                       gpr_wen,
  input  rv_regfile_pkg::gpr_idx_t   wb_rd,
  input  logic                       issue_valid,
  input  logic                       exu_ready,
  input  logic                       issue_wen,
  input  rv_regfile_pkg::gpr_idx_t   issue_rd,
  output logic [`RF_NUM_GPR-1:0]     wr_en,
  output logic [`RF_NUM_GPR-1:0]     set_busy,
  output logic [`RF_NUM_GPR-1:0]     clr_busy
);

  logic                   wb_fire;
  logic                   issue_fire;
  logic [`RF_NUM_GPR-1:0] wb_onehot;
  logic [`RF_NUM_GPR-1:0] issue_onehot;
  logic [`RF_NUM_GPR-1:0] x0_mask;

  assign wb_fire    = wbu_valid & gpr_wen;
  assign issue_fire = issue_valid & exu_ready & issue_wen;

  // x0 is hardwired, never enabled
  assign x0_mask = {{(`RF_NUM_GPR-1){1'b1}}, 1'b0};

  always_comb begin
    wb_onehot        = '0;
    wb_onehot[wb_rd] = 1'b1;
  end

  always_comb begin
    issue_onehot           = '0;
    issue_onehot[issue_rd] = 1'b1;
  end

  // Writeback writes the data and retires the busy bit together
  assign wr_en    = wb_fire ? (wb_onehot & x0_mask) : '0;
  assign clr_busy = wb_fire ? (wb_onehot & x0_mask) : '0;

  // Issue marks the destination pending
  assign set_busy = issue_fire ? (issue_onehot & x0_mask) : '0;

endmodule

// ==== rtl/gpr_cell.sv ====
`timescale 1ns/1ps
`include "rv_regfile_consts.svh"

module gpr_cell (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                wr_en,
  input  logic                set_busy,
  input  logic                clr_busy,
  input  logic [`RF_XLEN-1:0] wdata,
  output logic [`RF_XLEN-1:0] value,
  output logic                busy
);

  // Data word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      value <= '0;
    end else if (wr_en) begin
      value <= wdata;
    end
  end

  // ------------------------------------------------------------
  // Scoreboard bit
  // ------------------------------------------------------------
  // A new issue to the same register outranks the retiring write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
    end else if (set_busy) begin
      busy <= 1'b1;
    end else if (clr_busy) begin
      busy <= 1'b0;
    end
  end

endmodule

// ==== rtl/operand_read.sv ====
`timescale 1ns/1ps
`include "rv_regfile_consts.svh"

module operand_read (
  input  logic [`RF_NUM_GPR*`RF_XLEN-1:0] gpr_values,
  input  logic [`RF_NUM_GPR-1:0]          gpr_busy,
  input  rv_regfile_pkg::gpr_idx_t        rs1,
  input  rv_regfile_pkg::gpr_idx_t        rs2,
  output logic [`RF_XLEN-1:0]             src1,
  output logic [`RF_XLEN-1:0]             src2,
  output logic                            operands_ready
);

  logic [`RF_XLEN-1:0] gpr_word [`RF_NUM_GPR];
  logic                rs1_busy;
  logic                rs2_busy;

  // Unflatten the cell outputs
  always_comb begin
    for (int i = 0; i < `RF_NUM_GPR; i++) begin
      gpr_word[i] = gpr_values[i*`RF_XLEN +: `RF_XLEN];
    end
  end

  // ------------------------------------------------------------
  // Operand mux
  // ------------------------------------------------------------
  assign src1 = gpr_word[rs1];
  assign src2 = gpr_word[rs2];

  // x0 is never pending
  assign rs1_busy = (rs1 != '0) & gpr_busy[rs1];
  assign rs2_busy = (rs2 != '0) & gpr_busy[rs2];

  // Decode may proceed once both sources have been written back
  assign operands_ready = ~(rs1_busy | rs2_busy);

endmodule

// ==== rtl/csr_file.sv ====
`timescale 1ns/1ps
`include "rv_regfile_consts.svh"

module csr_file (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        wbu_valid,
  input  logic                        csr_wen,
  input  rv_regfile_pkg::csr_addr_t   wb_csr_addr,
  input  logic [`RF_XLEN-1:0]         csr_wdata,
  input  logic [`RF_XLEN-1:0]         wb_pc,
  input  logic                        ecall_en,
  input  logic                        mret_en,
  input  rv_regfile_pkg::csr_addr_t   csr_addr,
  input  logic                        inst_ecall,
  input  logic                        inst_mret,
  output logic [`RF_XLEN-1:0]         csr_rdata
);

  import rv_regfile_pkg::*;

  logic [`RF_XLEN-1:0] mtvec;
  logic [`RF_XLEN-1:0] mepc;
  logic [`RF_XLEN-1:0] mcause;
  mstatus_t            mstatus;
  mstatus_t            mstatus_ret;

  logic                do_ecall;
  logic                do_mret;
  logic                do_write;
  logic                wr_mtvec;
  logic                wr_mepc;
  logic                wr_mcause;
  logic                wr_mstatus;

  // ------------------------------------------------------------
  // Write decode
  // ------------------------------------------------------------
  assign do_ecall = wbu_valid & ecall_en;
  assign do_mret  = wbu_valid & mret_en & ~ecall_en;

  // Trap entry or return owns the CSR write slot that cycle
  assign do_write = wbu_valid & csr_wen & ~ecall_en & ~mret_en;

  assign wr_mtvec   = do_write & (wb_csr_addr == `CSR_MTVEC);
  assign wr_mepc    = do_write & (wb_csr_addr == `CSR_MEPC);
  assign wr_mcause  = do_write & (wb_csr_addr == `CSR_MCAUSE);
  assign wr_mstatus = do_write & (wb_csr_addr == `CSR_MSTATUS);

  // mret: restore MIE, set MPIE, drop back to MPP = 0
  always_comb begin
    mstatus_ret          = mstatus;
    mstatus_ret.fld.mie  = mstatus.fld.mpie;
    mstatus_ret.fld.mpie = 1'b1;
    mstatus_ret.fld.mpp  = 2'b00;
  end

  // ------------------------------------------------------------
  // CSR registers
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
      mstatus <= `MSTATUS_RESET;
    end else begin
      if (wr_mtvec) begin
        mtvec <= csr_wdata;
      end

      if (do_ecall) begin
        mepc        <= wb_pc;
        mcause      <= `MCAUSE_ECALL_M;
        mstatus     <= `MSTATUS_RESET;
      end else if (do_mret) begin
        mstatus     <= mstatus_ret;
      end else begin
        if (wr_mepc) begin
          mepc <= csr_wdata;
        end
        if (wr_mcause) begin
          mcause <= csr_wdata;
        end
        if (wr_mstatus) begin
          mstatus.word <= csr_wdata;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Read mux
  // ------------------------------------------------------------
  // ecall fetches the trap vector, mret fetches the return PC
  always_comb begin
    if (inst_ecall || (csr_addr == `CSR_MTVEC)) begin
      csr_rdata = mtvec;
    end else if (inst_mret || (csr_addr == `CSR_MEPC)) begin
      csr_rdata = mepc;
    end else begin
      case (csr_addr)
        `CSR_MSTATUS:   csr_rdata = mstatus.word;
        `CSR_MCAUSE:    csr_rdata = mcause;
        `CSR_MVENDORID: csr_rdata = `MVENDORID_VAL;
        `CSR_MARCHID:   csr_rdata = `MARCHID_VAL;
        default:        csr_rdata = '0;
      endcase
    end
  end

endmodule

// ==== rtl/regfile_top.sv ====
`timescale 1ns/1ps
`include "rv_regfile_consts.svh"

module regfile_top (
  input  logic                        clk,
  input  logic                        rst_n,
  // Writeback
  input  logic                        wbu_valid,
  input  logic                        gpr_wen,
  input  rv_regfile_pkg::gpr_idx_t    wb_rd,
  input  logic [`RF_XLEN-1:0]         gpr_wdata,
  input  logic                        csr_wen,
  input  rv_regfile_pkg::csr_addr_t   wb_csr_addr,
  input  logic [`RF_XLEN-1:0]         csr_wdata,
  input  logic [`RF_XLEN-1:0]         wb_pc,
  input  logic                        ecall_en,
  input  logic                        mret_en,
  // Issue
  input  logic                        issue_valid,
  input  logic                        exu_ready,
  input  logic                        issue_wen,
  input  rv_regfile_pkg::gpr_idx_t    issue_rd,
  // Decode read
  input  rv_regfile_pkg::gpr_idx_t    rs1,
  input  rv_regfile_pkg::gpr_idx_t    rs2,
  input  rv_regfile_pkg::csr_addr_t   csr_addr,
  input  logic                        inst_ecall,
  input  logic                        inst_mret,
  output logic [`RF_XLEN-1:0]         src1,
  output logic [`RF_XLEN-1:0]         src2,
  output logic                        operands_ready,
  output logic [`RF_XLEN-1:0]         csr_rdata
);

  logic [`RF_NUM_GPR-1:0]         wr_en;
  logic [`RF_NUM_GPR-1:0]         set_busy;
  logic [`RF_NUM_GPR-1:0]         clr_busy;
  logic [`RF_NUM_GPR*`RF_XLEN-1:0] gpr_values;
  logic [`RF_NUM_GPR-1:0]         gpr_busy;

  gpr_write_decode u_gpr_write_decode (
    .wbu_valid   (wbu_valid),
    .gpr_wen     (gpr_wen),
    .wb_rd       (wb_rd),
    .issue_valid (issue_valid),
    .exu_ready   (exu_ready),
    .issue_wen   (issue_wen),
    .issue_rd    (issue_rd),
    .wr_en       (wr_en),
    .set_busy    (set_busy),
    .clr_busy    (clr_busy)
  );

  // ------------------------------------------------------------
  // General-purpose registers
  // ------------------------------------------------------------
  for (genvar i = 0; i < `RF_NUM_GPR; i++) begin : g_gpr
    gpr_cell u_gpr_cell (
      .clk      (clk),
      .rst_n    (rst_n),
      .wr_en    (wr_en[i]),
      .set_busy (set_busy[i]),
      .clr_busy (clr_busy[i]),
      .wdata    (gpr_wdata),
      .value    (gpr_values[i*`RF_XLEN +: `RF_XLEN]),
      .busy     (gpr_busy[i])
    );
  end

  operand_read u_operand_read (
    .gpr_values     (gpr_values),
    .gpr_busy       (gpr_busy),
    .rs1            (rs1),
    .rs2            (rs2),
    .src1           (src1),
    .src2           (src2),
    .operands_ready (operands_ready)
  );

  csr_file u_csr_file (
    .clk         (clk),
    .rst_n       (rst_n),
    .wbu_valid   (wbu_valid),
    .csr_wen     (csr_wen),
    .wb_csr_addr (wb_csr_addr),
    .csr_wdata   (csr_wdata),
    .wb_pc       (wb_pc),
    .ecall_en    (ecall_en),
    .mret_en     (mret_en),
    .csr_addr    (csr_addr),
    .inst_ecall  (inst_ecall),
    .inst_mret   (inst_mret),
    .csr_rdata   (csr_rdata)
  );

endmodule

// ==== verif/regfile_tb.sv ====
`timescale 1ns/1ps
`include "rv_regfile_consts.svh"

module regfile_tb;

  localparam int N_OPS       = 2000;
  localparam int CLK_PERIOD  = 100;
  localparam int WATCHDOG_NS = (N_OPS + 20) * CLK_PERIOD;

  logic                      clk;
  logic                      rst_n;
  logic                      wbu_valid;
  logic                      gpr_wen;
  logic [`RF_IDX_W-1:0]      wb_rd;
  logic [`RF_XLEN-1:0]       gpr_wdata;
  logic                      csr_wen;
  logic [11:0]               wb_csr_addr;
  logic [`RF_XLEN-1:0]       csr_wdata;
  logic [`RF_XLEN-1:0]       wb_pc;
  logic                      ecall_en;
  logic                      mret_en;
  logic                      issue_valid;
  logic                      exu_ready;
  logic                      issue_wen;
  logic [`RF_IDX_W-1:0]      issue_rd;
  logic [`RF_IDX_W-1:0]      rs1;
  logic [`RF_IDX_W-1:0]      rs2;
  logic [11:0]               csr_addr;
  logic                      inst_ecall;
  logic                      inst_mret;
  logic [`RF_XLEN-1:0]       src1;
  logic [`RF_XLEN-1:0]       src2;
  logic                      operands_ready;
  logic [`RF_XLEN-1:0]       csr_rdata;

  // Reference model state
  logic [`RF_XLEN-1:0]       m_gpr [`RF_NUM_GPR];
  logic [`RF_NUM_GPR-1:0]    m_busy;
  logic [`RF_XLEN-1:0]       m_mtvec;
  logic [`RF_XLEN-1:0]       m_mepc;
  logic [`RF_XLEN-1:0]       m_mcause;
  logic [`RF_XLEN-1:0]       m_mstatus;

  logic [31:0]               lcg_state;
  int                        errors;
  int                        checks;

  regfile_top u_regfile_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .wbu_valid      (wbu_valid),
    .gpr_wen        (gpr_wen),
    .wb_rd          (wb_rd),
    .gpr_wdata      (gpr_wdata),
    .csr_wen        (csr_wen),
    .wb_csr_addr    (wb_csr_addr),
    .csr_wdata      (csr_wdata),
    .wb_pc          (wb_pc),
    .ecall_en       (ecall_en),
    .mret_en        (mret_en),
    .issue_valid    (issue_valid),
    .exu_ready      (exu_ready),
    .issue_wen      (issue_wen),
    .issue_rd       (issue_rd),
    .rs1            (rs1),
    .rs2            (rs2),
    .csr_addr       (csr_addr),
    .inst_ecall     (inst_ecall),
    .inst_mret      (inst_mret),
    .src1           (src1),
    .src2           (src2),
    .operands_ready (operands_ready),
    .csr_rdata      (csr_rdata)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------
  // Two LCG steps keep only the upper halves since the low bits cycle fast
  function automatic logic [31:0] next_rand();
    logic [15:0] hi;
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    hi        = lcg_state[31:16];
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {hi, lcg_state[31:16]};
  endfunction

  // Six implemented CSRs plus two that are not
  function automatic logic [11:0] csr_pick(input logic [2:0] sel);
    case (sel)
      3'd0:    return `CSR_MSTATUS;
      3'd1:    return `CSR_MTVEC;
      3'd2:    return `CSR_MEPC;
      3'd3:    return `CSR_MCAUSE;
      3'd4:    return `CSR_MVENDORID;
      3'd5:    return `CSR_MARCHID;
      3'd6:    return 12'h7C0;
      default: return 12'h301;
    endcase
  endfunction

  task automatic set_idle();
    wbu_valid   = 1'b0;
    gpr_wen     = 1'b0;
    wb_rd       = '0;
    gpr_wdata   = '0;
    csr_wen     = 1'b0;
    wb_csr_addr = '0;
    csr_wdata   = '0;
    wb_pc       = '0;
    ecall_en    = 1'b0;
    mret_en     = 1'b0;
    issue_valid = 1'b0;
    exu_ready   = 1'b0;
    issue_wen   = 1'b0;
    issue_rd    = '0;
    rs1         = '0;
    rs2         = '0;
    csr_addr    = '0;
    inst_ecall  = 1'b0;
    inst_mret   = 1'b0;
  endtask

  task automatic drive_random();
    logic [31:0] r;
    logic [31:0] s;
    r           = next_rand();
    s           = next_rand();
    wbu_valid   = r[0] | r[1];
    gpr_wen     = r[2];
    wb_rd       = r[7:4];
    gpr_wdata   = next_rand();
    csr_wen     = r[8];
    wb_csr_addr = csr_pick(r[11:9]);
    csr_wdata   = next_rand();
    wb_pc       = next_rand();
    ecall_en    = (r[15:12] == 4'd0);
    mret_en     = (r[19:16] == 4'd1);
    issue_valid = r[20];
    exu_ready   = r[21] | r[22];
    issue_wen   = r[23] | r[24];
    issue_rd    = r[28:25];
    rs1         = s[3:0];
    rs2         = s[7:4];
    csr_addr    = csr_pick(s[10:8]);
    inst_ecall  = (s[13:11] == 3'd0);
    inst_mret   = (s[16:14] == 3'd0);
  endtask

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------
  task automatic reset_model();
    for (int i = 0; i < `RF_NUM_GPR; i++) begin
      m_gpr[i] = '0;
    end
    m_busy    = '0;
    m_mtvec   = '0;
    m_mepc    = '0;
    m_mcause  = '0;
    m_mstatus = `MSTATUS_RESET;
  endtask

  // Called at the edge with the inputs of the ending cycle
  task automatic update_model();
    if (wbu_valid && gpr_wen && wb_rd != '0) begin
      m_gpr[wb_rd]  = gpr_wdata;
      m_busy[wb_rd] = 1'b0;
    end
    // Applied after the clear so that a same-register issue wins
    if (issue_valid && exu_ready && issue_wen && issue_rd != '0) begin
      m_busy[issue_rd] = 1'b1;
    end
    if (wbu_valid) begin
      if (ecall_en) begin
        m_mepc    = wb_pc;
        m_mcause  = `MCAUSE_ECALL_M;
        m_mstatus = `MSTATUS_RESET;
      end else if (mret_en) begin
        m_mstatus[3]     = m_mstatus[7];
        m_mstatus[7]     = 1'b1;
        m_mstatus[12:11] = 2'b00;
      end else if (csr_wen) begin
        case (wb_csr_addr)
          `CSR_MTVEC:   m_mtvec   = csr_wdata;
          `CSR_MEPC:    m_mepc    = csr_wdata;
          `CSR_MCAUSE:  m_mcause  = csr_wdata;
          `CSR_MSTATUS: m_mstatus = csr_wdata;
          default: ;
        endcase
      end
    end
  endtask

  function automatic logic [31:0] exp_csr(input logic [11:0] addr, input logic ie,
                                          input logic im);
    if (ie || addr == `CSR_MTVEC) return m_mtvec;
    if (im || addr == `CSR_MEPC) return m_mepc;
    case (addr)
      `CSR_MSTATUS:   return m_mstatus;
      `CSR_MCAUSE:    return m_mcause;
      `CSR_MVENDORID: return `MVENDORID_VAL;
      `CSR_MARCHID:   return `MARCHID_VAL;
      default:        return '0;
    endcase
  endfunction

  function automatic logic exp_ready(input logic [3:0] a, input logic [3:0] b);
    logic a_busy;
    logic b_busy;
    a_busy = (a != '0) && m_busy[a];
    b_busy = (b != '0) && m_busy[b];
    return !(a_busy || b_busy);
  endfunction

  // ------------------------------------------------------------
  // Checking
  // ------------------------------------------------------------
  task automatic check_val(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s expected 0x%08h actual 0x%08h at %0d ns",
               name, expected, actual, $time);
    end
  endtask

  task automatic check_outputs();
    check_val("src1", m_gpr[rs1], src1);
    check_val("src2", m_gpr[rs2], src2);
    check_val("operands_ready", {31'd0, exp_ready(rs1, rs2)}, {31'd0, operands_ready});
    check_val("csr_rdata", exp_csr(csr_addr, inst_ecall, inst_mret), csr_rdata);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    lcg_state = 32'h4e39;
    errors    = 0;
    checks    = 0;
    set_idle();
    reset_model();
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Reset state over every register and CSR selector once
    for (int i = 0; i < 8; i++) begin
      rs1      = 4'(i);
      rs2      = 4'(i + 8);
      csr_addr = csr_pick(3'(i));
      #97;
      check_outputs();
      @(posedge clk);
      #1;
    end

    for (int n = 0; n < N_OPS; n++) begin
      drive_random();
      #97;
      check_outputs();
      @(posedge clk);
      update_model();
      #1;
    end

    $display("Checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/rv_regfile_pkg.sv
rtl/gpr_write_decode.sv
rtl/gpr_cell.sv
rtl/operand_read.sv
rtl/csr_file.sv
rtl/regfile_top.sv
verif/regfile_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the register file testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM_BIN=regfile_tb_sim

verilator --binary --timing \
  -f sources.f \
  --top-module regfile_tb \
  --Mdir "$BUILD_DIR" \
  -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qF '*** FAILED ***' "$LOG"; then
  exit 1
fi
exit 0
